/* files.f */
src/piano_pkg.sv
src/spi_frame_rx.sv
src/envelope_gen.sv
src/voice_mixer.sv
src/dac_serializer.sv
src/piano_top.sv
dv/piano_tb.sv

/* dv/piano_tb.sv */
// piano synthesizer testbench
// random spi note frames against a cycle model, DAC frames decoded from the pins
module piano_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import piano_pkg::*;

    localparam int STEP_CYCLES    = 64;
    localparam int SCK_HALF       = 6;    // clk cycles per sck level
    localparam int PRE_FRAMES     = 4;
    localparam int NOTE_FRAMES    = 40;
    localparam int MAX_GAP        = 1500;
    localparam int FRAME_TIME     = FRAME_W * 2 * SCK_HALF + MAX_GAP;
    localparam int TIMEOUT_CYCLES = (PRE_FRAMES + 1 + NOTE_FRAMES) * FRAME_TIME
                                    + ENV_STEPS * STEP_CYCLES * 2 + 5000;
    localparam int BITS_END       = (DAC_PRE_BITS + SAMPLE_W) * DAC_BIT_CYCLES;
    localparam int LOAD_END       = BITS_END + DAC_LOAD_CYCLES;
    localparam int LDAC_END       = LOAD_END + DAC_LDAC_CYCLES;

    // rise, peak, then decay
    localparam logic [7:0] GAIN_STEPS [16] = '{
        8'h1C, 8'h34, 8'h35, 8'h3D, 8'h80, 8'h7C, 8'h7A, 8'h6B,
        8'h69, 8'h53, 8'h51, 8'h3F, 8'h2E, 8'h1A, 8'h0D, 8'h03
    };

    logic                  clk;
    logic                  rst;
    logic                  sck;
    logic                  sdi;
    logic                  dclk;
    logic                  data;
    logic                  load;
    logic                  ldac;
    logic [NUM_VOICES-1:0] voice_active;
    logic [NUM_VOICES-1:0] voice_done;

    // cycle model state
    logic [2:0]            m_sck;       // pin history three cycles deep
    logic [1:0]            m_sdi;
    logic [FRAME_W-1:0]    m_shift;
    logic                  m_locked;
    int                    m_bits;
    logic                  m_latch;
    sample_t               m_notes [NUM_VOICES];
    count_t                m_count;
    sample_t               m_prev [NUM_VOICES];
    int                    m_step [NUM_VOICES];
    int                    m_cnt [NUM_VOICES];
    sample_t               m_env [NUM_VOICES];
    logic [NUM_VOICES-1:0] m_active;
    logic [NUM_VOICES-1:0] m_done;
    sample_t               m_mix;
    int                    m_fc;
    logic                  m_dclk;
    logic                  m_load;
    logic                  m_ldac;
    logic                  m_data_zero;
    bit                    m_started = 0;
    sample_t               exp_q [$];   // mix captured at each frame start

    logic [DAC_WORD_BITS-1:0] dac_word;
    int                       dac_bits = 0;
    logic                     dclk_q = 0;
    int                       frames_seen = 0;
    int                       cycles = 0;
    bit                       sync_sent = 0;
    sample_t                  last_sent [NUM_VOICES];

    piano_top #(
        .ENV_STEP_CYCLES (STEP_CYCLES)
    ) piano_top_inst (
        .clk          (clk),
        .rst          (rst),
        .sck          (sck),
        .sdi          (sdi),
        .dclk         (dclk),
        .data         (data),
        .load         (load),
        .ldac         (ldac),
        .voice_active (voice_active),
        .voice_done   (voice_done)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_sample(input string name, input sample_t got, input sample_t exp);
        if (got !== exp)
            abort_run($sformatf("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    task automatic check_flags(input string name, input logic [NUM_VOICES-1:0] got,
                               input logic [NUM_VOICES-1:0] exp);
        if (got !== exp)
            abort_run($sformatf("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    task automatic check_pin(input string name, input logic got, input logic exp);
        if (got !== exp)
            abort_run($sformatf("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    function automatic sample_t apply_gain(input sample_t note, input int step);
        logic [7:0] gain;
        int         acc;
        if (step >= ENV_STEPS)
            return '0;
        gain = GAIN_STEPS[step];
        acc  = gain[7] ? int'(note) : 0;
        for (int s = 1; s < 8; s++)
        begin
            if (gain[7-s])
                acc = acc + (int'(note) >> s);
        end
        return acc[7:0];
    endfunction

    function automatic sample_t mix_rule();
        int sum;
        int n;
        int r;
        sum = 0;
        n   = 0;
        for (int v = 0; v < NUM_VOICES; v++)
        begin
            if (v < int'(m_count))
            begin
                sum = sum + int'(m_env[v]);
                n   = n + (m_active[v] ? 1 : 0);
            end
        end
        case (n)
            1:       r = sum;
            2:       r = sum >> 1;
            3:       r = (sum >> 2) + (sum >> 4) + (sum >> 6) + (sum >> 8);
            default: r = 0;
        endcase
        return (r > 255) ? 8'hFF : r[7:0];
    endfunction

    task automatic step_voice(input int v);
        m_env[v] = apply_gain(m_notes[v], m_step[v]);
        if (m_notes[v] == '0)
        begin
            m_step[v]   = 0;
            m_cnt[v]    = 0;
            m_active[v] = 1'b0;
            m_done[v]   = 1'b0;
        end
        else if (m_notes[v] != m_prev[v])   // new strike
        begin
            m_step[v]   = 0;
            m_cnt[v]    = 0;
            m_active[v] = 1'b1;
            m_done[v]   = 1'b0;
        end
        else if (m_step[v] < ENV_STEPS)
        begin
            if (m_cnt[v] == STEP_CYCLES - 1)
            begin
                m_cnt[v]  = 0;
                m_step[v] = m_step[v] + 1;
                if (m_step[v] == ENV_STEPS)
                begin
                    m_active[v] = 1'b0;
                    m_done[v]   = 1'b1;
                end
            end
            else
                m_cnt[v] = m_cnt[v] + 1;
        end
        m_prev[v] = m_notes[v];
    endtask

    // stages run back to front so each one reads last cycle's values
    always @(posedge clk)
    begin
        if (rst)
        begin
            m_sck    = '0;
            m_sdi    = '0;
            m_shift  = '1;   // receiver starts from all ones
            m_locked = 1'b0;
            m_bits   = 0;
            m_latch  = 1'b0;
            m_count  = '0;
            m_active = '0;
            m_done   = '0;
            m_mix    = '0;
            m_fc     = 0;
            for (int v = 0; v < NUM_VOICES; v++)
            begin
                m_notes[v] = '0;
                m_prev[v]  = '0;
                m_env[v]   = '0;
                m_step[v]  = 0;
                m_cnt[v]   = 0;
            end
            m_dclk      = 1'b0;
            m_load      = 1'b1;
            m_ldac      = 1'b1;
            m_data_zero = 1'b1;
        end
        else
        begin
            if (m_fc == 0)
                exp_q.push_back(m_mix);
            m_dclk      = (m_fc < BITS_END) && (m_fc % DAC_BIT_CYCLES < DAC_DCLK_FALL);
            m_load      = !(m_fc >= BITS_END && m_fc < LOAD_END);
            m_ldac      = !(m_fc >= LOAD_END && m_fc < LDAC_END);
            m_data_zero = (m_fc >= BITS_END);
            m_fc        = (m_fc == DAC_FRAME_CYCLES - 1) ? 0 : m_fc + 1;
            m_mix = mix_rule();
            for (int v = 0; v < NUM_VOICES; v++)
                step_voice(v);
            if (m_latch)
            begin
                for (int v = 0; v < NUM_VOICES; v++)
                    m_notes[v] = m_shift[SAMPLE_W*v +: SAMPLE_W];
                m_count = m_shift[25:24];
            end
            m_latch = 1'b0;
            if (m_sck[1] && !m_sck[2])
            begin
                m_shift = {m_shift[FRAME_W-2:0], m_sdi[1]};
                if (!m_locked)
                    m_locked = (m_shift == SYNC_WORD);
                else
                begin
                    m_bits = m_bits + 1;
                    if (m_bits == FRAME_W)
                    begin
                        m_bits  = 0;
                        m_latch = 1'b1;
                    end
                end
            end
            m_sck = {m_sck[1:0], sck};
            m_sdi = {m_sdi[0], sdi};
        end
        m_started = 1;
    end

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles > TIMEOUT_CYCLES)
            abort_run($sformatf("timeout: no end of test after %0d cycles", cycles));
    end

    always @(negedge clk)
    begin
        if (m_started)
        begin
            if (!load && !ldac)
                abort_run("load and ldac are low in the same cycle");
            if (!sync_sent)
            begin
                check_flags("voice_active before sync", voice_active, '0);
                check_flags("voice_done before sync", voice_done, '0);
            end
            check_pin("dclk", dclk, m_dclk);
            check_pin("load", load, m_load);
            check_pin("ldac", ldac, m_ldac);
            if (m_data_zero)
                check_pin("data", data, 1'b0);
            check_flags("voice_active", voice_active, m_active);
            check_flags("voice_done", voice_done, m_done);
            if (dclk_q && !dclk)   // the DAC takes data here
            begin
                dac_word = {dac_word[DAC_WORD_BITS-2:0], data};
                dac_bits = dac_bits + 1;
                if (dac_bits == DAC_WORD_BITS)
                begin
                    dac_bits = 0;
                    for (int j = 0; j < DAC_PRE_BITS; j++)
                        check_pin("data control bit", dac_word[DAC_WORD_BITS-1-j], 1'b0);
                    if (exp_q.size() == 0)
                        abort_run("a DAC frame was decoded before any sample was captured");
                    else
                        check_sample("dac sample", dac_word[SAMPLE_W-1:0], exp_q.pop_front());
                    frames_seen = frames_seen + 1;
                end
            end
            dclk_q = dclk;
        end
    end

    task automatic send_frame(input logic [FRAME_W-1:0] frame);
        for (int i = FRAME_W - 1; i >= 0; i--)
        begin
            sck = 1'b0;
            sdi = frame[i];
            repeat (SCK_HALF) @(negedge clk);
            sck = 1'b1;
            repeat (SCK_HALF) @(negedge clk);
        end
    endtask

    function automatic logic [FRAME_W-1:0] make_note_frame();
        logic [FRAME_W-1:0] frame;
        int                 pick;
        frame = $urandom();   // note_count and unused top bits random
        for (int v = 0; v < NUM_VOICES; v++)
        begin
            pick = $urandom_range(7);
            if (pick < 2)
                frame[SAMPLE_W*v +: SAMPLE_W] = last_sent[v];   // held key keeps its envelope
            else if (pick == 2)
                frame[SAMPLE_W*v +: SAMPLE_W] = '0;
            else
                frame[SAMPLE_W*v +: SAMPLE_W] = $urandom_range(255, 1);
            last_sent[v] = frame[SAMPLE_W*v +: SAMPLE_W];
        end
        return frame;
    endfunction

    initial
    begin
        logic [FRAME_W-1:0] frame;
        int                 target;
        rst = 1'b1;
        sck = 1'b0;
        sdi = 1'b0;
        void'($urandom(69209));
        for (int v = 0; v < NUM_VOICES; v++)
            last_sent[v] = '0;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        for (int f = 0; f < PRE_FRAMES; f++)
        begin
            frame     = $urandom();
            frame[15] = 1'b1;   // breaks every 16-zero run so the receiver stays unlocked
            frame[31] = 1'b1;
            send_frame(frame);
            repeat ($urandom_range(MAX_GAP)) @(negedge clk);
        end
        send_frame(SYNC_WORD);
        sync_sent = 1;
        for (int f = 0; f < NOTE_FRAMES; f++)
        begin
            send_frame(make_note_frame());
            repeat ($urandom_range(MAX_GAP)) @(negedge clk);
        end
        while (m_active != '0)
            @(negedge clk);
        target = frames_seen + 2;
        while (frames_seen < target)
            @(negedge clk);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* src/piano_top.sv */
// three-voice piano synthesizer top level
// spi note frames in, enveloped and mixed samples out to a serial DAC
module piano_top #(
    parameter int ENV_STEP_CYCLES = piano_pkg::ENV_STEP_CYCLES_DEF
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             sck,
    input  logic                             sdi,
    output logic                             dclk,
    output logic                             data,
    output logic                             load,
    output logic                             ldac,
    output logic [piano_pkg::NUM_VOICES-1:0] voice_active,
    output logic [piano_pkg::NUM_VOICES-1:0] voice_done
);
    import piano_pkg::*;

    sample_t notes [NUM_VOICES];        // levels, change only at frame end
    count_t  note_count;
    sample_t env_samples [NUM_VOICES];
    sample_t mix_sample;

    spi_frame_rx spi_frame_rx_inst (
        .clk        (clk),
        .rst        (rst),
        .sck        (sck),
        .sdi        (sdi),
        .notes      (notes),
        .note_count (note_count)
    );

    for (genvar v = 0; v < NUM_VOICES; v++)
    begin : g_voice
        envelope_gen #(
            .ENV_STEP_CYCLES (ENV_STEP_CYCLES)
        ) envelope_gen_inst (
            .clk        (clk),
            .rst        (rst),
            .note       (notes[v]),
            .env_sample (env_samples[v]),
            .active     (voice_active[v]),
            .done       (voice_done[v])
        );
    end

    voice_mixer voice_mixer_inst (
        .clk        (clk),
        .rst        (rst),
        .env_sample (env_samples),
        .active     (voice_active),
        .note_count (note_count),
        .mix_sample (mix_sample)
    );

    dac_serializer dac_serializer_inst (
        .clk        (clk),
        .rst        (rst),
        .mix_sample (mix_sample),
        .data       (data),
        .dclk       (dclk),
        .load       (load),
        .ldac       (ldac)
    );

endmodule

/* src/dac_serializer.sv */
// serial DAC frame generator
// shifts 4 zero control bits and the sample msb first, then pulses load and ldac
module dac_serializer (
    input  logic               clk,
    input  logic               rst,
    input  piano_pkg::sample_t mix_sample,
    output logic               data,
    output logic               dclk,
    output logic               load,
    output logic               ldac
);
    import piano_pkg::*;

    logic [$clog2(DAC_FRAME_CYCLES)-1:0] frame_cnt;
    logic [$clog2(DAC_BIT_CYCLES)-1:0]   phase;
    logic [DAC_WORD_BITS-1:0]            word;
    logic                                frame_last;
    logic                                in_bits;
    logic                                in_load;
    logic                                in_ldac;

    assign frame_last = (frame_cnt == DAC_FRAME_CYCLES - 1);
    assign in_bits    = (frame_cnt < DAC_SHIFT_CYCLES);
    assign in_load    = !in_bits && (frame_cnt < DAC_SHIFT_CYCLES + DAC_LOAD_CYCLES);
    assign in_ldac    = (frame_cnt >= DAC_SHIFT_CYCLES + DAC_LOAD_CYCLES) && !frame_last;

    always_ff @(posedge clk)
    begin
        if (rst || frame_last)
        begin
            frame_cnt <= '0;
            phase     <= '0;  // frame length is not a whole number of bits
        end
        else
        begin
            frame_cnt <= frame_cnt + 1'b1;
            if (phase == DAC_BIT_CYCLES - 1)
                phase <= '0;
            else
                phase <= phase + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (frame_cnt == '0)
            word <= {{DAC_PRE_BITS{1'b0}}, mix_sample};
        else if (in_bits && phase == DAC_DATA_PHASE)
            word <= word << 1;
    end

    // pins follow the frame counter by one cycle
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            dclk <= 1'b0;
            data <= 1'b0;
            load <= 1'b1;
            ldac <= 1'b1;
        end
        else
        begin
            load <= !in_load;
            ldac <= !in_ldac;
            if (in_bits)
            begin
                if (phase == '0)
                    dclk <= 1'b1;
                else if (phase == DAC_DCLK_FALL)
                    dclk <= 1'b0;
                if (phase == DAC_DATA_PHASE)
                    data <= word[DAC_WORD_BITS-1];
            end
            else
            begin
                dclk <= 1'b0;
                data <= 1'b0;
            end
        end
    end

    // the DAC must see the word latched before the output update
    assert property (@(posedge clk) disable iff (rst) load || ldac)
        else $error("dac_serializer: load and ldac low together");

endmodule

/* src/voice_mixer.sv */
// voice mixer
// sums the voices in use and divides by the number still sounding
module voice_mixer (
    input  logic                             clk,
    input  logic                             rst,
    input  piano_pkg::sample_t               env_sample [piano_pkg::NUM_VOICES],
    input  logic [piano_pkg::NUM_VOICES-1:0] active,
    input  piano_pkg::count_t                note_count,
    output piano_pkg::sample_t               mix_sample
);
    import piano_pkg::*;

    logic [NUM_VOICES-1:0] in_use;
    count_t                n_active;
    mix_t                  sum;
    mix_t                  scaled;

    always_comb
    begin
        n_active = '0;
        sum      = '0;
        for (int i = 0; i < NUM_VOICES; i++)
        begin
            in_use[i] = (i < note_count);  // voices past note_count are muted
            if (in_use[i])
            begin
                sum = sum + env_sample[i];
                if (active[i])
                    n_active = n_active + 1'b1;
            end
        end
    end

    always_comb
    begin
        case (n_active)
            2'd1:    scaled = sum;
            2'd2:    scaled = sum >> 1;
            2'd3:    scaled = (sum >> 2) + (sum >> 4) + (sum >> 6) + (sum >> 8);  // ~sum/3
            default: scaled = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            mix_sample <= '0;
        else if (scaled > mix_t'({SAMPLE_W{1'b1}}))
            mix_sample <= '1;  // clip at full scale
        else
            mix_sample <= scaled[SAMPLE_W-1:0];
    end

endmodule

/* src/envelope_gen.sv */
// per-voice key envelope
// steps through the gain table and scales the note with shifted copies
module envelope_gen #(
    parameter int ENV_STEP_CYCLES = piano_pkg::ENV_STEP_CYCLES_DEF
) (
    input  logic               clk,
    input  logic               rst,
    input  piano_pkg::sample_t note,
    output piano_pkg::sample_t env_sample,
    output logic               active,
    output logic               done
);
    import piano_pkg::*;

    logic [$clog2(ENV_STEP_CYCLES+1)-1:0] cycle_cnt;
    sample_t                              note_q;   // previous note for change detect
    step_t                                step;
    env_gain_t                            gain;
    sample_t                              scaled;
    logic                                 step_end;

    assign step_end = (cycle_cnt == ENV_STEP_CYCLES - 1);
    assign gain     = (step == ENV_STEPS) ? '0 : ENV_GAIN_TABLE[step[3:0]];

    // table entries keep this sum within 8 bits
    always_comb
    begin
        scaled = gain[7] ? note : '0;
        for (int k = 0; k < 7; k++)
        begin
            if (gain[k])
                scaled = scaled + (note >> (7 - k));
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            note_q     <= '0;
            step       <= '0;
            cycle_cnt  <= '0;
            active     <= 1'b0;
            done       <= 1'b0;
            env_sample <= '0;
        end
        else
        begin
            note_q     <= note;
            env_sample <= scaled;
            if (note == '0)            // key released, voice goes quiet
            begin
                step      <= '0;
                cycle_cnt <= '0;
                active    <= 1'b0;
                done      <= 1'b0;
            end
            else if (note != note_q)   // new key strike restarts the envelope
            begin
                step      <= '0;
                cycle_cnt <= '0;
                active    <= 1'b1;
                done      <= 1'b0;
            end
            else if (step != ENV_STEPS)
            begin
                if (step_end)
                begin
                    cycle_cnt <= '0;
                    step      <= step + 1'b1;
                    if (step == ENV_STEPS - 1)
                    begin
                        active <= 1'b0;
                        done   <= 1'b1;
                    end
                end
                else
                    cycle_cnt <= cycle_cnt + 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) !(active && done))
        else $error("envelope_gen: voice flagged active and done together");

endmodule

/* src/spi_frame_rx.sv */
// receive-only spi frame receiver
// brings sck/sdi into the clk domain, locks on the sync word and latches note frames
module spi_frame_rx (
    input  logic               clk,
    input  logic               rst,
    input  logic               sck,
    input  logic               sdi,
    output piano_pkg::sample_t notes [piano_pkg::NUM_VOICES],
    output piano_pkg::count_t  note_count
);
    import piano_pkg::*;

    logic [2:0]               sck_sync;   // two sync stages plus edge history
    logic [1:0]               sdi_sync;
    logic                     sck_rise;
    logic [FRAME_W-1:0]       shift_reg;
    logic [FRAME_W-1:0]       shift_next;
    logic                     locked;
    logic [$clog2(FRAME_W):0] bit_cnt;
    logic                     frame_done;

    assign sck_rise   = sck_sync[1] & ~sck_sync[2];
    assign shift_next = {shift_reg[FRAME_W-2:0], sdi_sync[1]};

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            sck_sync <= '0;
            sdi_sync <= '0;
        end
        else
        begin
            sck_sync <= {sck_sync[1:0], sck};
            sdi_sync <= {sdi_sync[0], sdi};
        end
    end

    // all-ones start needs a full 16 zeros shifted in before a match
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            shift_reg  <= '1;
            locked     <= 1'b0;
            bit_cnt    <= '0;
            frame_done <= 1'b0;
        end
        else
        begin
            frame_done <= 1'b0;
            if (sck_rise)
            begin
                shift_reg <= shift_next;
                if (!locked)
                    locked <= (shift_next == SYNC_WORD);
                else if (bit_cnt == FRAME_W - 1)
                begin
                    bit_cnt    <= '0;
                    frame_done <= 1'b1;  // 32nd shift of the frame
                end
                else
                    bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            notes      <= '{default: '0};
            note_count <= '0;
        end
        else if (frame_done)
        begin
            for (int i = 0; i < NUM_VOICES; i++)
                notes[i] <= shift_reg[SAMPLE_W*i +: SAMPLE_W];
            note_count <= shift_reg[NOTE_COUNT_LSB +: COUNT_W];
        end
    end

    // frames stay aligned once the sync word has been seen
    assert property (@(posedge clk) disable iff (rst)
        locked |-> bit_cnt <= FRAME_W - 1)
        else $error("spi_frame_rx: bit counter ran past the frame length");

endmodule

/* src/piano_pkg.sv */
// piano synthesizer shared definitions
// sample widths, spi frame layout, envelope gain table and DAC frame timing
package piano_pkg;

    localparam int NUM_VOICES = 3;
    localparam int SAMPLE_W   = 8;
    localparam int MIX_W      = 10;  // holds the sum of three full-scale voices
    localparam int COUNT_W    = 2;

    typedef logic [SAMPLE_W-1:0] sample_t;
    typedef logic [MIX_W-1:0]    mix_t;
    typedef logic [COUNT_W-1:0]  count_t;

    // note i sits at [8i+7:8i], note count at [25:24], top bits unused
    localparam int                 FRAME_W        = 32;
    localparam logic [FRAME_W-1:0] SYNC_WORD      = 32'h0000_FFFF;
    localparam int                 NOTE_COUNT_LSB = 24;

    localparam int ENV_STEPS = 16;
    typedef logic [4:0] step_t;      // value ENV_STEPS marks a finished voice
    typedef logic [7:0] env_gain_t;

    // bit 7 passes the whole note, bit k below it adds note >> (7-k)
    localparam env_gain_t ENV_GAIN_TABLE [ENV_STEPS] = '{
        8'h1C,
        8'h34,
        8'h35,
        8'h3D,
        8'h80,                       // peak
        8'h7C,
        8'h7A,
        8'h6B,
        8'h69,
        8'h53,
        8'h51,
        8'h3F,
        8'h2E,
        8'h1A,
        8'h0D,
        8'h03
    };

    localparam int ENV_STEP_CYCLES_DEF = 7500000;

    localparam int DAC_BIT_CYCLES   = 40;
    localparam int DAC_PRE_BITS     = 4;   // zero control bits ahead of the sample
    localparam int DAC_WORD_BITS    = DAC_PRE_BITS + SAMPLE_W;
    localparam int DAC_SHIFT_CYCLES = DAC_WORD_BITS * DAC_BIT_CYCLES;
    localparam int DAC_LOAD_CYCLES  = 40;
    localparam int DAC_LDAC_CYCLES  = 40;
    localparam int DAC_FRAME_CYCLES = DAC_SHIFT_CYCLES + DAC_LOAD_CYCLES
                                      + DAC_LDAC_CYCLES + 1;
    localparam int DAC_DATA_PHASE   = 7;   // data changes while dclk is high
    localparam int DAC_DCLK_FALL    = 20;  // DAC samples here

endpackage
